//--- rv_core.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_core.sv
bench/rv_core_properties.sv
bench/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/rv_core_tb.sv
`include "rv_defs.svh"

module rv_core_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 256;
    localparam int RUN_LIMIT  = 2000;  // cycles allowed per program

    logic                clk = 1'b0;
    logic                rst_n;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] imem_inst;
    logic [`RV_XLEN-1:0] dmem_addr;
    logic [`RV_XLEN-1:0] dmem_rdata;
    logic [`RV_XLEN-1:0] dmem_wdata;
    logic                dmem_wen;
    logic                exit_sig;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];

    // architectural model
    logic [31:0] ref_x [`RV_REG_COUNT];
    logic [31:0] ref_dmem [DMEM_WORDS];
    logic [31:0] ref_pc;
    logic        ref_halted;
    logic [31:0] exp_pc;
    logic        exp_exit;
    logic        exp_wen;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic        rst_edge_seen = 1'b0;

    logic [31:0] rng_state = 32'h3b63;
    int          err_count = 0;
    int          mem_mismatch = 0;
    logic [31:0] prog [$];

    rv_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_inst_i  (imem_inst),
        .dmem_addr_o  (dmem_addr),
        .dmem_rdata_i (dmem_rdata),
        .dmem_wdata_o (dmem_wdata),
        .dmem_wen_o   (dmem_wen),
        .exit_o       (exit_sig)
    );

    always #4 clk = ~clk;

    assign imem_inst  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input rv_opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return i_type(imm, rs1, 3'b000, rd, OPC_OP_IMM);
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return i_type(imm, rs1, 3'b010, rd, OPC_LOAD);
    endfunction

    function automatic logic [31:0] ecall_word();
        return {25'd0, OPC_SYSTEM};
    endfunction

    // one instruction of the RV32I subset against the model state
    function automatic void ref_step(input logic [31:0] inst);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] res;
        logic        wr;
        opc   = inst[6:0];
        f3    = inst[14:12];
        f7    = inst[31:25];
        rd    = inst[11:7];
        a     = ref_x[inst[19:15]];
        b     = ref_x[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        res   = 32'd0;
        wr    = 1'b0;
        exp_pc    = ref_pc;
        exp_wen   = 1'b0;
        exp_addr  = 32'd0;
        exp_wdata = 32'd0;
        exp_exit  = ref_halted;
        if (ref_halted) begin
            return;
        end
        if (opc == 7'b0000011 && f3 == 3'b010) begin
            res = ref_dmem[(a + imm_i) >> 2 & 32'hff];
            wr  = 1'b1;
        end else if (opc == 7'b0100011 && f3 == 3'b010) begin
            exp_wen   = 1'b1;
            exp_addr  = a + imm_s;
            exp_wdata = b;
            ref_dmem[exp_addr[9:2]] = b;
        end else if (opc == 7'b0110011 || opc == 7'b0010011) begin
            if (opc == 7'b0010011) begin
                b = imm_i;
            end
            wr = 1'b1;
            if (opc == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) begin
                res = a - b;
            end else if (opc == 7'b0110011 && f7 != 7'b0000000) begin
                wr = 1'b0;
            end else if (f3 == 3'b000) begin
                res = a + b;
            end else if (f3 == 3'b111) begin
                res = a & b;
            end else if (f3 == 3'b110) begin
                res = a | b;
            end else if (f3 == 3'b100) begin
                res = a ^ b;
            end else begin
                wr = 1'b0;
            end
        end else if (opc == 7'b1110011 && inst[31:7] == 25'd0) begin
            ref_halted = 1'b1;
            exp_exit   = 1'b1;
        end
        if (wr && rd != 5'd0) begin
            ref_x[rd] = res;
        end
        if (!ref_halted) begin
            ref_pc = ref_pc + 32'd4;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // compare process, mid-cycle where all outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("dmem_wen_o", {31'd0, dmem_wen}, 32'd0);
            check_value("exit_o", {31'd0, exit_sig}, 32'd0);
            if (rst_edge_seen) begin
                check_value("imem_addr_o", imem_addr, 32'd0);  // cleared by a reset edge
            end
            rst_edge_seen = 1'b1;
            ref_pc     = 32'd0;
            ref_halted = 1'b0;
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                ref_x[i] = 32'd0;
            end
        end else begin
            rst_edge_seen = 1'b0;
            ref_step(imem[ref_pc[11:2]]);
            check_value("imem_addr_o", imem_addr, exp_pc);
            check_value("exit_o", {31'd0, exit_sig}, {31'd0, exp_exit});
            check_value("dmem_wen_o", {31'd0, dmem_wen}, {31'd0, exp_wen});
            if (exp_wen) begin
                check_value("dmem_addr_o", dmem_addr, exp_addr);
                check_value("dmem_wdata_o", dmem_wdata, exp_wdata);
            end
        end
    end

    task automatic load_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : ecall_word();
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]     = 32'h5a5a_0000 ^ (i * 32'h9e37_79b1);
            ref_dmem[i] = dmem[i];
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        rst_n = 1'b0;
        load_program();
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        cycles = 0;
        while (!exit_sig && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!exit_sig) begin
            $display("%s: timed out waiting for the core to halt", name);
            $display("check errors: %0d, memory mismatches: %0d", err_count, mem_mismatch);
            $display("Simulation failed");
            $finish;
        end
        repeat (4) @(posedge clk);  // pc must hold and nothing may be stored
        for (int i = 0; i < DMEM_WORDS; i++) begin
            assert (dmem[i] === ref_dmem[i]) else begin
                mem_mismatch++;
                $display("Error: dmem[%0d] got %h expected %h", i, dmem[i], ref_dmem[i]);
            end
        end
        #1 rst_n = 1'b0;
    endtask

    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [11:0] off;
        r   = rand_next();
        off = {r[26:17], 2'b00};
        case (r[31:29])
            3'd0: return load_word(r[4:0], 5'd0, off);
            3'd1: return s_type(off, r[14:10], 5'd0);
            3'd2: return r_type(r[27] ? 7'b0100000 : 7'b0000000, r[14:10], r[9:5],
                                3'b000, r[4:0]);
            3'd3: return r_type(7'd0, r[14:10], r[9:5], 3'b111, r[4:0]);
            3'd4: return r_type(7'd0, r[14:10], r[9:5], 3'b110, r[4:0]);
            3'd5: return r_type(7'd0, r[14:10], r[9:5], 3'b100, r[4:0]);
            3'd6: return addi(r[4:0], r[9:5], r[26:15]);
            default: return i_type(r[26:15], r[9:5], r[28] ? 3'b111 : (r[27] ? 3'b110 : 3'b100),
                                   r[4:0], OPC_OP_IMM);
        endcase
    endfunction

    initial begin
        rst_n = 1'b0;

        // constants, ALU ops and stores of every result
        prog = '{addi(1, 0, 12'h123), addi(2, 0, 12'hfff), addi(3, 0, 12'h800),
                 addi(4, 0, 12'h7ff), addi(5, 0, 12'h100),
                 r_type(7'h00, 2, 1, 3'b000, 6), s_type(12'd0, 6, 5),
                 r_type(7'h20, 3, 1, 3'b000, 7), s_type(12'd4, 7, 5),
                 r_type(7'h00, 4, 2, 3'b111, 8), s_type(12'd8, 8, 5),
                 r_type(7'h00, 3, 1, 3'b110, 9), s_type(12'd12, 9, 5),
                 r_type(7'h00, 1, 2, 3'b100, 10), s_type(12'd16, 10, 5),
                 i_type(12'hff0, 1, 3'b111, 11, OPC_OP_IMM), s_type(12'd20, 11, 5),
                 i_type(12'h055, 3, 3'b110, 12, OPC_OP_IMM), s_type(12'd24, 12, 5),
                 i_type(12'hfff, 1, 3'b100, 13, OPC_OP_IMM), s_type(12'd28, 13, 5),
                 ecall_word()};
        run_program("alu");

        // negative offsets, load round trip and x0
        prog = '{addi(5, 0, 12'h200), addi(6, 0, 12'hb2e), s_type(12'hff8, 6, 5),
                 load_word(7, 5, 12'hff8), s_type(12'hffc, 7, 5),
                 addi(0, 6, 12'd5), r_type(7'h00, 6, 0, 3'b000, 8), s_type(12'd0, 8, 5),
                 s_type(12'd4, 0, 5), ecall_word()};
        run_program("load_store");

        // undecoded words retire as no-ops
        prog = '{addi(1, 0, 12'd77), 32'hffff_ffff, 32'h0000_1093, 32'h0000_0000,
                 s_type(12'h040, 1, 0), ecall_word()};
        run_program("undecoded");

        prog = {};
        for (int i = 0; i < 200; i++) begin
            prog.push_back(random_inst());
        end
        prog.push_back(ecall_word());
        run_program("random");

        $display("check errors: %0d, memory mismatches: %0d", err_count, mem_mismatch);
        if (err_count == 0 && mem_mismatch == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- bench/rv_core_properties.sv
module rv_core_properties (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] pc,
    input logic        exit_o,
    input logic        dmem_wen_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // halt is sticky until the next reset
    exit_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) exit_o |=> exit_o
    ) else $error("exit_o dropped while the core was halted");

    pc_frozen: assert property (
        @(posedge clk) disable iff (!rst_n) exit_o |=> $stable(pc)
    ) else $error("pc moved while exit_o was high");

    // a halted core never writes memory again
    no_store_after_exit: assert property (
        @(posedge clk) disable iff (!rst_n) exit_o |=> !dmem_wen_o
    ) else $error("dmem_wen_o high after exit");

endmodule

bind rv_core rv_core_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .exit_o     (exit_o),
    .dmem_wen_o (dmem_wen_o)
);

//--- rtl/rv_core.sv
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    output logic [`RV_XLEN-1:0] imem_addr_o,
    input  logic [`RV_XLEN-1:0] imem_inst_i,
    output logic [`RV_XLEN-1:0] dmem_addr_o,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i,
    output logic [`RV_XLEN-1:0] dmem_wdata_o,
    output logic                dmem_wen_o,
    output logic                exit_o
);

    logic [`RV_XLEN-1:0]       pc;
    logic                      halt;
    logic                      exit;

    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_REG_ADDR_W-1:0] rd_addr;
    logic                      rf_wen;
    logic                      mem_wen;
    rv_alu_op_e                alu_op;
    rv_op2_sel_e               op2_sel;
    rv_wb_sel_e                wb_sel;
    logic [`RV_XLEN-1:0]       imm;

    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic [`RV_XLEN-1:0]       alu_result;
    logic [`RV_XLEN-1:0]       wb_data;
    logic                      commit;
    logic                      rf_wr_en;

    rv_fetch u_fetch (
        .clk    (clk),
        .rst_n  (rst_n),
        .halt_i (halt),
        .pc_o   (pc),
        .exit_o (exit)
    );

    rv_decoder u_decoder (
        .inst_i     (imem_inst_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .rf_wen_o   (rf_wen),
        .mem_wen_o  (mem_wen),
        .halt_o     (halt),
        .alu_op_o   (alu_op),
        .op2_sel_o  (op2_sel),
        .wb_sel_o   (wb_sel),
        .imm_o      (imm)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_addr_i  (rd_addr),
        .wr_en_i    (rf_wr_en),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .alu_op_i   (alu_op),
        .op2_sel_i  (op2_sel),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .result_o   (alu_result)
    );

    // nothing retires in reset or once halted
    assign commit   = rst_n & ~exit;
    assign rf_wr_en = rf_wen & commit;

    assign wb_data = (wb_sel == WB_MEM) ? dmem_rdata_i : alu_result;

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_result;  // rs1 + sext(imm) for lw and sw
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = mem_wen & commit;
    assign exit_o       = exit;

endmodule

//--- rtl/rv_alu.sv
`include "rv_defs.svh"

module rv_alu import rv_pkg::*; (
    input  rv_alu_op_e          alu_op_i,
    input  rv_op2_sel_e         op2_sel_i,
    input  logic [`RV_XLEN-1:0] rs1_data_i,
    input  logic [`RV_XLEN-1:0] rs2_data_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    output logic [`RV_XLEN-1:0] result_o
);

    logic [`RV_XLEN-1:0] op2;

    assign op2 = (op2_sel_i == OP2_IMM) ? imm_i : rs2_data_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = rs1_data_i + op2;  // wraps at 32 bits
            ALU_SUB: result_o = rs1_data_i - op2;
            ALU_AND: result_o = rs1_data_i & op2;
            ALU_OR:  result_o = rs1_data_i | op2;
            ALU_XOR: result_o = rs1_data_i ^ op2;
            default: result_o = '0;
        endcase
    end

endmodule

//--- rtl/rv_regfile.sv
`include "rv_defs.svh"

module rv_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0] wr_addr_i,
    input  logic                      wr_en_i,
    input  logic [`RV_XLEN-1:0]       wr_data_i,
    output logic [`RV_XLEN-1:0]       rs1_data_o,
    output logic [`RV_XLEN-1:0]       rs2_data_o
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // reads see the value from before this cycle's write
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- rtl/rv_decoder.sv
`include "rv_defs.svh"

module rv_decoder import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0]       inst_i,
    output logic [`RV_REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`RV_REG_ADDR_W-1:0] rs2_addr_o,
    output logic [`RV_REG_ADDR_W-1:0] rd_addr_o,
    output logic                      rf_wen_o,
    output logic                      mem_wen_o,
    output logic                      halt_o,
    output rv_alu_op_e                alu_op_o,
    output rv_op2_sel_e               op2_sel_o,
    output rv_wb_sel_e                wb_sel_o,
    output logic [`RV_XLEN-1:0]       imm_o
);

    rv_opcode_e          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [11:0]         imm_i;
    logic [11:0]         imm_s;
    logic [`RV_XLEN-1:0] imm_i_sext;
    logic [`RV_XLEN-1:0] imm_s_sext;
    logic                is_store;

    assign opcode = rv_opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i = inst_i[31:20];
    assign imm_s = {inst_i[31:25], inst_i[11:7]};

    assign imm_i_sext = {{(`RV_XLEN-12){imm_i[11]}}, imm_i};
    assign imm_s_sext = {{(`RV_XLEN-12){imm_s[11]}}, imm_s};

    assign is_store = (opcode == OPC_STORE);
    assign imm_o    = is_store ? imm_s_sext : imm_i_sext;

    // only the exact ecall encoding halts
    assign halt_o = (opcode == OPC_SYSTEM) && (inst_i[31:7] == '0);

    always_comb begin
        // anything not matched below retires as a no-op
        rf_wen_o  = 1'b0;
        mem_wen_o = 1'b0;
        alu_op_o  = ALU_ADD;
        op2_sel_o = OP2_IMM;
        wb_sel_o  = WB_ALU;

        case (opcode)
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin  // lw
                    rf_wen_o = 1'b1;
                    wb_sel_o = WB_MEM;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin  // sw
                    mem_wen_o = 1'b1;
                end
            end
            OPC_OP: begin
                op2_sel_o = OP2_RS2;
                if (funct7 == 7'b0000000) begin
                    rf_wen_o = 1'b1;
                    case (funct3)
                        3'b000:  alu_op_o = ALU_ADD;
                        3'b111:  alu_op_o = ALU_AND;
                        3'b110:  alu_op_o = ALU_OR;
                        3'b100:  alu_op_o = ALU_XOR;
                        default: rf_wen_o = 1'b0;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    rf_wen_o = 1'b1;
                    alu_op_o = ALU_SUB;
                end
            end
            OPC_OP_IMM: begin
                rf_wen_o = 1'b1;
                case (funct3)
                    3'b000:  alu_op_o = ALU_ADD;
                    3'b111:  alu_op_o = ALU_AND;
                    3'b110:  alu_op_o = ALU_OR;
                    3'b100:  alu_op_o = ALU_XOR;
                    default: rf_wen_o = 1'b0;  // shifts and compares unsupported
                endcase
            end
            default: begin
                rf_wen_o = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/rv_fetch.sv
`include "rv_defs.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                halt_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic                exit_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic                halted_q;
    logic                stop;

    assign stop = halted_q | halt_i;  // freeze in the ecall cycle itself

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
        end else if (!stop) begin
            pc_q <= pc_q + 'd4;
        end else begin
            halted_q <= 1'b1;  // sticky, pc stays put from here on
        end
    end

    assign pc_o   = pc_q;
    assign exit_o = stop & rst_n;

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } rv_alu_op_e;

    // immediate format is resolved in the decoder
    typedef enum logic {
        OP2_RS2 = 1'b0,
        OP2_IMM = 1'b1
    } rv_op2_sel_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } rv_wb_sel_e;

endpackage

//--- rtl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath word width
`define RV_XLEN         32

// architectural register file geometry
`define RV_REG_COUNT    32
`define RV_REG_ADDR_W   5

`endif
